// ==== dcache_pkg.sv ====
package dcache_pkg;

    // Cache geometry. The way count is tied to the one-hot way select width.
    localparam int num_ways       = 4;
    localparam int line_bits      = 512;
    localparam int word_bits      = 32;
    localparam int words_per_line = 16;

    // Byte address bits 31 to 6. The full line address is kept as the tag.
    typedef logic [25:0] line_tag_t;

    typedef logic [num_ways-1:0] way_sel_t;  // One-hot, all zeros selects no way.

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cache_op_e;

    typedef enum logic [1:0] {
        RF_IDLE,
        RF_WRITEBACK,
        RF_FILL,
        RF_DONE
    } refill_state_e;

    // Access descriptor registered by the tag stage.
    typedef struct packed {
        cache_op_e            op;
        line_tag_t            line_addr;
        logic [3:0]           word_index;
        logic [word_bits-1:0] wdata;
        way_sel_t             hit_way;
        way_sel_t             victim_way;
        logic                 victim_dirty;
        line_tag_t            victim_addr;  // Line address currently held by the victim way.
    } cache_req_t;

    typedef struct packed {
        logic                 valid;
        logic                 write;
        line_tag_t            line_addr;
        logic [line_bits-1:0] wline;
    } mem_req_t;

    typedef struct packed {
        logic                 ack;
        logic [line_bits-1:0] rdata;  // Valid in the ack cycle of a read.
    } mem_rsp_t;

endpackage

// ==== dcache_tag_stage.sv ====
`timescale 1ns/1ps

module dcache_tag_stage
    import dcache_pkg::*;
#(
    parameter int  num_sets = 16,
    localparam int idx_bits = $clog2(num_sets)
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [31:0]         paddr,
    input  logic [31:0]         pwdata,
    input  logic [31:0]         rd_word,
    input  logic                fill_done,
    input  way_sel_t            fill_way,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    output cache_req_t          req,
    output logic                req_valid,
    output logic [idx_bits-1:0] set_index,
    output logic                miss_start
);

    line_tag_t           tag_q   [num_sets][num_ways];
    logic [num_ways-1:0] valid_q [num_sets];
    logic [num_ways-1:0] dirty_q [num_sets];
    logic [1:0]          rr_q    [num_sets];
    logic                err_q;

    logic                access;
    logic                first_cycle;
    logic                misaligned;
    logic                req_hit;
    logic                found;
    line_tag_t           line_addr;
    logic [idx_bits-1:0] req_set;
    way_sel_t            hit_vec;
    way_sel_t            victim_vec;
    logic                victim_dirty;
    line_tag_t           victim_addr;

    assign access      = psel && penable;
    assign first_cycle = access && !req_valid;  // First cycle of the access phase.
    assign misaligned  = paddr[1:0] != 2'b00;
    assign line_addr   = paddr[31:6];
    assign set_index   = paddr[6 +: idx_bits];
    assign req_set     = req.line_addr[idx_bits-1:0];
    assign req_hit     = req.hit_way != '0;

    always_comb begin
        hit_vec    = '0;
        victim_vec = '0;
        found      = 1'b0;
        for (int w = 0; w < num_ways; w++) begin
            hit_vec[w] = valid_q[set_index][w] && (tag_q[set_index][w] == line_addr);
        end
        // The lowest invalid way is taken first.
        for (int w = 0; w < num_ways; w++) begin
            if (!found && !valid_q[set_index][w]) begin
                victim_vec[w] = 1'b1;
                found         = 1'b1;
            end
        end
        if (!found) begin
            victim_vec[rr_q[set_index]] = 1'b1;
        end
        victim_addr = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (victim_vec[w]) begin
                victim_addr = tag_q[set_index][w];
            end
        end
        victim_dirty = |(victim_vec & dirty_q[set_index]);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req        <= '0;
            req_valid  <= 1'b0;
            err_q      <= 1'b0;
            miss_start <= 1'b0;
        end else begin
            miss_start <= first_cycle && !misaligned && (hit_vec == '0);
            if (first_cycle) begin
                req.op           <= pwrite ? OP_WRITE : OP_READ;
                req.line_addr    <= line_addr;
                req.word_index   <= paddr[5:2];
                req.wdata        <= pwdata;
                req.hit_way      <= misaligned ? '0 : hit_vec;
                req.victim_way   <= victim_vec;
                req.victim_dirty <= victim_dirty;
                req.victim_addr  <= victim_addr;
                req_valid        <= 1'b1;
                err_q            <= misaligned;
            end else if (pready) begin
                req_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                rr_q[s]    <= '0;
            end
        end else if (fill_done) begin
            valid_q[req_set] <= valid_q[req_set] | fill_way;
            if (req.op == OP_WRITE) begin
                dirty_q[req_set] <= dirty_q[req_set] | fill_way;
            end else begin
                dirty_q[req_set] <= dirty_q[req_set] & ~fill_way;
            end
            rr_q[req_set] <= rr_q[req_set] + 2'd1;
        end else if (req_valid && req_hit && req.op == OP_WRITE) begin
            dirty_q[req_set] <= dirty_q[req_set] | req.hit_way;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            for (int w = 0; w < num_ways; w++) begin
                if (fill_way[w]) begin
                    tag_q[req_set][w] <= req.line_addr;
                end
            end
        end
    end

    // A hit or error completes in the second access cycle, a miss with the fill.
    assign pready  = req_valid && (err_q || req_hit || fill_done);
    assign pslverr = req_valid && err_q;
    assign prdata  = rd_word;

endmodule

// ==== dcache_data_ram.sv ====
`timescale 1ns/1ps

module dcache_data_ram
    import dcache_pkg::*;
#(
    parameter int  num_sets = 16,
    localparam int idx_bits = $clog2(num_sets)
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [idx_bits-1:0]           set_index,
    input  logic                          fill_we,
    input  way_sel_t                      fill_way,
    input  logic [line_bits-1:0]          fill_line,
    input  logic                          word_we,
    input  way_sel_t                      word_way,
    input  logic [3:0]                    word_index,
    input  logic [word_bits-1:0]          word_data,
    output logic [num_ways*line_bits-1:0] set_dout
);

    logic [line_bits-1:0] line_mem [num_sets][num_ways];

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (fill_we && fill_way[w]) begin
                line_mem[set_index][w] <= fill_line;
            end
            // The later assignment wins, so a store merges into the line being filled.
            if (word_we && (word_way[w] || (fill_we && fill_way[w]))) begin
                line_mem[set_index][w][word_index*word_bits +: word_bits] <= word_data;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            set_dout <= '0;
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                set_dout[w*line_bits +: line_bits] <= line_mem[set_index][w];
            end
        end
    end

endmodule

// ==== dcache_rd_sel.sv ====
`timescale 1ns/1ps

module dcache_rd_sel
    import dcache_pkg::*;
(
    input  logic [num_ways*line_bits-1:0]     set_dout,
    input  way_sel_t                          hit_way,
    input  logic [$clog2(words_per_line)-1:0] word_index,
    input  logic [line_bits-1:0]              fill_line,
    input  logic                              from_fill,
    input  way_sel_t                          victim_way,
    output logic [word_bits-1:0]              rd_word,
    output logic [line_bits-1:0]              victim_line
);

    logic [line_bits-1:0] hit_line;
    logic [word_bits-1:0] ram_word;
    logic [word_bits-1:0] fill_word;

    // Returns the line of the selected way, or zeros unless sel is one-hot.
    function automatic logic [line_bits-1:0] pick_line(input way_sel_t sel);
        case (sel)
            4'b0001: pick_line = set_dout[0*line_bits +: line_bits];
            4'b0010: pick_line = set_dout[1*line_bits +: line_bits];
            4'b0100: pick_line = set_dout[2*line_bits +: line_bits];
            4'b1000: pick_line = set_dout[3*line_bits +: line_bits];
            default: pick_line = '0;
        endcase
    endfunction

    always_comb begin
        hit_line    = pick_line(hit_way);
        victim_line = pick_line(victim_way);
    end

    always_comb begin
        ram_word  = hit_line[word_index*word_bits +: word_bits];
        fill_word = fill_line[word_index*word_bits +: word_bits];
    end

    // During the fill the RAM still holds the old line.
    always_comb begin
        case (from_fill)
            1'b1:    rd_word = fill_word;
            default: rd_word = ram_word;
        endcase
    end

endmodule

// ==== dcache_refill.sv ====
`timescale 1ns/1ps

module dcache_refill
    import dcache_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 miss_start,
    input  cache_req_t           req,
    input  logic [line_bits-1:0] victim_line,
    input  mem_rsp_t             mem_rsp,
    output mem_req_t             mem_req,
    output logic                 fill_done,
    output logic                 fill_we,
    output logic [line_bits-1:0] fill_line,
    output logic                 from_fill
);

    refill_state_e state_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= RF_IDLE;
            mem_req <= '0;
        end else begin
            unique case (state_q)
                RF_IDLE: begin
                    if (miss_start) begin
                        mem_req.valid     <= 1'b1;
                        mem_req.write     <= req.victim_dirty;
                        mem_req.line_addr <= req.victim_dirty ? req.victim_addr : req.line_addr;
                        mem_req.wline     <= victim_line;
                        state_q           <= req.victim_dirty ? RF_WRITEBACK : RF_FILL;
                    end
                end
                RF_WRITEBACK: begin
                    if (mem_rsp.ack) begin
                        mem_req.valid <= 1'b0;
                        state_q       <= RF_FILL;
                    end
                end
                RF_FILL: begin
                    if (!mem_req.valid) begin
                        mem_req.valid     <= 1'b1;  // Fill request after the writeback.
                        mem_req.write     <= 1'b0;
                        mem_req.line_addr <= req.line_addr;
                    end else if (mem_rsp.ack) begin
                        mem_req.valid <= 1'b0;
                        state_q       <= RF_DONE;
                    end
                end
                RF_DONE: begin
                    state_q <= RF_IDLE;
                end
                default: begin
                    state_q <= RF_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == RF_FILL && mem_req.valid && mem_rsp.ack) begin
            fill_line <= mem_rsp.rdata;
        end
    end

    // Tags, line and store are all installed in the single done cycle.
    assign fill_done = state_q == RF_DONE;
    assign fill_we   = state_q == RF_DONE;
    assign from_fill = state_q == RF_DONE;

endmodule

// ==== dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
#(
    parameter int  num_sets = 16,
    localparam int idx_bits = $clog2(num_sets)
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output mem_req_t    mem_req,
    input  mem_rsp_t    mem_rsp
);

    cache_req_t                    req;
    logic                          req_valid;
    logic [idx_bits-1:0]           set_index;
    logic                          miss_start;
    logic                          fill_done;
    logic                          fill_we;
    logic                          from_fill;
    logic [line_bits-1:0]          fill_line;
    logic [line_bits-1:0]          victim_line;
    logic [num_ways*line_bits-1:0] set_dout;
    logic [word_bits-1:0]          rd_word;

    dcache_tag_stage #(.num_sets(num_sets)) u_tag_stage (
        .clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .rd_word, .fill_done, .fill_way(req.victim_way),
        .prdata, .pready, .pslverr, .req, .req_valid, .set_index, .miss_start
    );

    // A store of the live access lands on the hit way or the way being filled.
    dcache_data_ram #(.num_sets(num_sets)) u_data_ram (
        .clk, .arst_n, .set_index, .fill_we, .fill_way(req.victim_way), .fill_line,
        .word_we(req_valid && req.op == OP_WRITE), .word_way(req.hit_way),
        .word_index(req.word_index), .word_data(req.wdata), .set_dout
    );

    dcache_rd_sel u_rd_sel (
        .set_dout, .hit_way(req.hit_way), .word_index(req.word_index), .fill_line,
        .from_fill, .victim_way(req.victim_way), .rd_word, .victim_line
    );

    dcache_refill u_refill (
        .clk, .arst_n, .miss_start, .req, .victim_line, .mem_rsp,
        .mem_req, .fill_done, .fill_we, .fill_line, .from_fill
    );

endmodule

// ==== tb_dcache_top.sv ====
`timescale 1ns/1ps

module tb_dcache_top
    import dcache_pkg::*;
();

    localparam int          num_sets    = 16;
    localparam int          num_lines   = 256;  // Lines in the 16 KB test window.
    localparam int          max_wait    = 200;
    localparam int          num_ops     = 2000;
    localparam logic [31:0] window_base = 32'h2000_0000;

    logic        clk;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;

    integer               seed = 32'h315bb2de;
    logic [line_bits-1:0] mem_line   [num_lines];
    logic [word_bits-1:0] model_word [num_lines*words_per_line];  // What each word must read as.
    int                   mem_req_count = 0;

    dcache_top #(.num_sets(num_sets)) u_dcache_top (
        .clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .mem_req, .mem_rsp
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [word_bits-1:0] exp,
                              input logic [word_bits-1:0] act);
        if (act !== exp) begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            report_failure("Data word mismatch.");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: %s expected %b actual %b", name, exp, act);
            report_failure("Flag mismatch.");
        end
    endtask

    task automatic check_line(input string name, input mem_req_t exp, input mem_req_t act);
        if (act !== exp) begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            report_failure("Memory request mismatch.");
        end
    endtask

    function automatic int word_slot(input logic [31:0] addr);
        word_slot = addr[13:2];
    endfunction

    function automatic logic [line_bits-1:0] model_line(input int idx);
        for (int w = 0; w < words_per_line; w++) begin
            model_line[w*word_bits +: word_bits] = model_word[idx*words_per_line + w];
        end
    endfunction

    function automatic logic [31:0] random_addr();
        random_addr = window_base | ($random(seed) & 32'h0000_3ffc);
    endfunction

    // Cycles counts the access-phase cycles up to and including the one with pready.
    task automatic apb_transfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err, output int cycles);
        logic done;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (pready) begin
                done  = 1'b1;
                rdata = prdata;
                err   = pslverr;
            end else if (cycles >= max_wait) begin
                report_failure("APB transfer got no pready within 200 cycles.");
            end
            @(posedge clk);
        end
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_and_check(input string name, input logic [31:0] addr, output int cycles);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b0, addr, 32'h0, rdata, err, cycles);
        check_flag($sformatf("%s pslverr at %h", name, addr), 1'b0, err);
        check_word($sformatf("%s at %h", name, addr), model_word[word_slot(addr)], rdata);
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        int          cycles;
        apb_transfer(1'b1, addr, data, rdata, err, cycles);
        check_flag($sformatf("write pslverr at %h", addr), 1'b0, err);
        model_word[word_slot(addr)] = data;
    endtask

    // Memory acks each request after 1 to 8 cycles and checks every writeback line.
    initial begin : memory_responder
        mem_req_t             held;
        mem_req_t             expected;
        logic [line_bits-1:0] rline;
        int                   idx;
        int                   delay;
        int                   waited;
        mem_rsp = '0;
        forever begin
            @(negedge clk);
            if (mem_req.valid) begin
                held = mem_req;
                mem_req_count++;
                if (held.line_addr[25:8] != window_base[31:14]) begin
                    report_failure("Memory request outside the test window.");
                end
                idx   = held.line_addr[7:0];
                rline = mem_line[idx];
                if (held.write) begin
                    expected.valid     = 1'b1;
                    expected.write     = 1'b1;
                    expected.line_addr = held.line_addr;
                    expected.wline     = model_line(idx);
                    check_line($sformatf("writeback of line %h", held.line_addr), expected, held);
                    mem_line[idx] = held.wline;
                end
                delay = 1 + ($unsigned($random(seed)) % 8);
                repeat (delay) @(posedge clk);
                mem_rsp.ack   <= 1'b1;
                mem_rsp.rdata <= rline;
                @(posedge clk);
                mem_rsp.ack <= 1'b0;
                waited = 0;
                @(negedge clk);
                while (mem_req.valid) begin
                    waited++;
                    if (waited >= max_wait) begin
                        report_failure("Memory request stayed valid for 200 cycles after ack.");
                    end
                    @(negedge clk);
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0] addr;
        logic [31:0] last_addr;
        logic [31:0] data;
        logic [31:0] rdata;
        logic        err;
        int          cycles;
        int          count_before;
        int          pick;
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int i = 0; i < num_lines*words_per_line; i++) begin
            data          = $random(seed);
            model_word[i] = data;
            mem_line[i/words_per_line][(i%words_per_line)*word_bits +: word_bits] = data;
        end
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        // Nothing is valid after reset, so the first read needs exactly one fill.
        count_before = mem_req_count;
        addr         = random_addr();
        read_and_check("first read", addr, cycles);
        check_word("first read fill requests", 32'd1, mem_req_count - count_before);
        last_addr = addr;

        for (int n = 0; n < num_ops; n++) begin
            pick = $unsigned($random(seed)) % 100;
            if (pick < 40) begin
                addr = random_addr();
                read_and_check("random read", addr, cycles);
                last_addr = addr;
            end else if (pick < 80) begin
                addr = random_addr();
                data = $random(seed);
                write_word(addr, data);
                read_and_check("write readback", addr, cycles);
                last_addr = addr;
            end else if (pick < 90) begin
                addr = random_addr() | (1 + ($unsigned($random(seed)) % 3));
                data = $random(seed);
                count_before = mem_req_count;
                apb_transfer(data[31], addr, data, rdata, err, cycles);
                check_flag($sformatf("misaligned pslverr at %h", addr), 1'b1, err);
                check_word("misaligned memory requests", count_before, mem_req_count);
            end else begin
                read_and_check("hit re-read", last_addr, cycles);
                check_word("hit re-read access cycles", 32'd2, cycles);
            end
        end

        for (int i = 0; i < num_lines*words_per_line; i++) begin
            read_and_check("final sweep", window_base + i*4, cycles);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== dcache_top.f ====
dcache_pkg.sv
dcache_tag_stage.sv
dcache_data_ram.sv
dcache_rd_sel.sv
dcache_refill.sv
dcache_top.sv
tb_dcache_top.sv
